/* rtl/mips_pkg.sv */
package mips_pkg;

    ////////////////////////////////////////
    // Basic types

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;

    // Cycles until a result can be forwarded
    typedef logic [1:0]  tnew_t;

    // Primary opcode, instr[31:26]
    typedef enum logic [5:0] {
        OP_SPECIAL = 6'b000000,
        OP_J       = 6'b000010,
        OP_BEQ     = 6'b000100,
        OP_ORI     = 6'b001101,
        OP_LUI     = 6'b001111,
        OP_LW      = 6'b100011,
        OP_SW      = 6'b101011
    } op_e;

    localparam logic [5:0] FUNCT_ADDU = 6'b100001;
    localparam logic [5:0] FUNCT_SUBU = 6'b100011;

    localparam word_t RESET_PC = 32'h0000_3000;

    typedef enum logic [1:0] {
        ALU_ADD = 2'd0,
        ALU_SUB = 2'd1,
        ALU_OR  = 2'd2,
        ALU_LUI = 2'd3
    } alu_op_e;

    ////////////////////////////////////////
    // Pipeline payloads, all-zero is a bubble

    typedef struct packed {
        word_t instr;
        word_t pc;
    } fd_t;

    typedef struct packed {
        word_t       pc;
        logic [15:0] imm;
        reg_addr_t   rs;
        reg_addr_t   rt;
        word_t       rs_val;
        word_t       rt_val;
        reg_addr_t   dst;
        alu_op_e     alu_op;
        logic        imm_sel;
        logic        mem_read;
        logic        mem_write;
        tnew_t       tnew;
    } dx_t;

    typedef struct packed {
        word_t     pc;
        word_t     alu_res;
        word_t     store_data;
        reg_addr_t rt;
        reg_addr_t dst;
        logic      mem_read;
        logic      mem_write;
        tnew_t     tnew;
    } xm_t;

    typedef struct packed {
        word_t     pc;
        word_t     value;
        reg_addr_t dst;
        logic      we;
    } mw_t;

    // Register-file write port, also the trace
    typedef struct packed {
        logic      we;
        reg_addr_t dst;
        word_t     data;
        word_t     pc;
    } wb_t;

    // Operand bypass: memory stage first, then writeback
    function automatic word_t fwd_val(reg_addr_t src, word_t stale, xm_t m, wb_t w);
        word_t val;
        if (src == '0) begin
            val = '0;
        end else if (m.dst == src && !m.mem_read) begin
            val = m.alu_res;
        end else if (w.we && w.dst == src) begin
            val = w.data;
        end else begin
            val = stale;
        end
        return val;
    endfunction

endpackage

/* rtl/fetch_stage.sv */
module fetch_stage #(
    parameter mips_pkg::word_t RESET_PC = mips_pkg::RESET_PC
) (
    input  logic            clk_i,
    input  logic            rst_n_i,
    input  logic            stall_i,
    input  logic            redirect_i,
    input  mips_pkg::word_t redirect_pc_i,
    output mips_pkg::word_t i_inst_addr_o,
    input  mips_pkg::word_t i_inst_rdata_i,
    output mips_pkg::fd_t   fd_o
);
    import mips_pkg::*;

    word_t pc_q;
    word_t pc_next;
    fd_t   fd_q;

    // Redirect lands after the delay slot, which is fetched this cycle
    assign pc_next = redirect_i ? redirect_pc_i : pc_q + 32'd4;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            pc_q <= RESET_PC;
            fd_q <= '0;
        end else if (!stall_i) begin
            pc_q       <= pc_next;
            fd_q.instr <= i_inst_rdata_i;
            fd_q.pc    <= pc_q;
        end
    end

    assign i_inst_addr_o = pc_q;
    assign fd_o          = fd_q;

    // Targets from decode must keep the PC on a word boundary
    pc_aligned_a: assert property (
        @(posedge clk_i) disable iff (!rst_n_i) pc_q[1:0] == 2'b00
    );

endmodule

/* rtl/decode_stage.sv */
module decode_stage (
    input  logic            clk_i,
    input  logic            rst_n_i,
    input  mips_pkg::fd_t   fd_i,
    input  mips_pkg::dx_t   dx_q_i,
    input  mips_pkg::xm_t   fwd_m_i,
    input  mips_pkg::wb_t   wb_i,
    output logic            stall_o,
    output logic            redirect_o,
    output mips_pkg::word_t redirect_pc_o,
    output mips_pkg::dx_t   dx_o
);
    import mips_pkg::*;

    word_t       rf_q [32];
    op_e         op;
    reg_addr_t   rs;
    reg_addr_t   rt;
    reg_addr_t   rd;
    logic [5:0]  funct;
    logic [15:0] imm;
    word_t       pc_plus4;
    word_t       rs_val;
    word_t       rt_val;
    logic        use_rs;
    logic        use_rt;
    logic        is_beq;
    logic        is_j;
    tnew_t       tuse;
    logic        stall_rs;
    logic        stall_rt;
    dx_t         ctl;

    assign op       = op_e'(fd_i.instr[31:26]);
    assign rs       = fd_i.instr[25:21];
    assign rt       = fd_i.instr[20:16];
    assign rd       = fd_i.instr[15:11];
    assign funct    = fd_i.instr[5:0];
    assign imm      = fd_i.instr[15:0];
    assign pc_plus4 = fd_i.pc + 32'd4;

    ////////////////////////////////////////
    // Register file

    always_ff @(posedge clk_i) begin
        if (wb_i.we) begin
            rf_q[wb_i.dst] <= wb_i.data;
        end
    end

    // Writeback bypass doubles as write-before-read
    assign rs_val = fwd_val(rs, rf_q[rs], fwd_m_i, wb_i);
    assign rt_val = fwd_val(rt, rf_q[rt], fwd_m_i, wb_i);

    ////////////////////////////////////////
    // Control decode

    always_comb begin
        ctl        = '0;
        ctl.pc     = fd_i.pc;
        ctl.imm    = imm;
        ctl.rs     = rs;
        ctl.rt     = rt;
        ctl.rs_val = rs_val;
        ctl.rt_val = rt_val;
        use_rs     = 1'b0;
        use_rt     = 1'b0;
        is_beq     = 1'b0;
        is_j       = 1'b0;
        tuse       = 2'd1;
        case (op)
            OP_SPECIAL: begin
                if (funct == FUNCT_ADDU || funct == FUNCT_SUBU) begin
                    ctl.dst    = rd;
                    ctl.alu_op = (funct == FUNCT_SUBU) ? ALU_SUB : ALU_ADD;
                    ctl.tnew   = 2'd1;
                    use_rs     = 1'b1;
                    use_rt     = 1'b1;
                end
            end
            OP_ORI: begin
                ctl.dst     = rt;
                ctl.alu_op  = ALU_OR;
                ctl.imm_sel = 1'b1;
                ctl.tnew    = 2'd1;
                use_rs      = 1'b1;
            end
            OP_LUI: begin
                ctl.dst     = rt;
                ctl.alu_op  = ALU_LUI;
                ctl.imm_sel = 1'b1;
                ctl.tnew    = 2'd1;
            end
            OP_LW: begin
                ctl.dst      = rt;
                ctl.imm_sel  = 1'b1;
                ctl.mem_read = 1'b1;
                ctl.tnew     = 2'd2;
                use_rs       = 1'b1;
            end
            OP_SW: begin
                ctl.imm_sel   = 1'b1;
                ctl.mem_write = 1'b1;
                use_rs        = 1'b1;
                use_rt        = 1'b1;
            end
            OP_BEQ: begin
                // Compared here, so needed right away
                is_beq = 1'b1;
                use_rs = 1'b1;
                use_rt = 1'b1;
                tuse   = 2'd0;
            end
            OP_J: begin
                is_j = 1'b1;
            end
            default: begin
                // Anything else goes down the pipe as a nop
            end
        endcase
    end

    ////////////////////////////////////////
    // Hazards and branch resolution

    assign stall_rs = use_rs && rs != '0 &&
        ((dx_q_i.dst == rs && dx_q_i.tnew > tuse) ||
         (fwd_m_i.dst == rs && fwd_m_i.tnew > tuse));
    assign stall_rt = use_rt && rt != '0 &&
        ((dx_q_i.dst == rt && dx_q_i.tnew > tuse) ||
         (fwd_m_i.dst == rt && fwd_m_i.tnew > tuse));
    assign stall_o  = stall_rs || stall_rt;

    assign redirect_o    = ((is_beq && rs_val == rt_val) || is_j) && !stall_o;
    assign redirect_pc_o = is_j ? {pc_plus4[31:28], fd_i.instr[25:0], 2'b00}
                                : pc_plus4 + {{14{imm[15]}}, imm, 2'b00};

    assign dx_o = stall_o ? '0 : ctl;

    // Tnew never exceeds two, so a hazard clears within two cycles
    stall_bounded_a: assert property (
        @(posedge clk_i) disable iff (!rst_n_i) (stall_o && $past(stall_o)) |=> !stall_o
    );

endmodule

/* rtl/execute_stage.sv */
module execute_stage (
    input  logic          clk_i,
    input  logic          rst_n_i,
    input  mips_pkg::dx_t dx_i,
    input  mips_pkg::xm_t fwd_m_i,
    input  mips_pkg::wb_t wb_i,
    output mips_pkg::dx_t dx_q_o,
    output mips_pkg::xm_t xm_o
);
    import mips_pkg::*;

    dx_t   dx_q;
    word_t op_a;
    word_t op_b;
    word_t imm_ext;
    word_t src_b;
    word_t alu_res;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            dx_q <= '0;
        end else begin
            dx_q <= dx_i;
        end
    end

    assign dx_q_o = dx_q;

    // Producers that were still in flight during decode
    assign op_a = fwd_val(dx_q.rs, dx_q.rs_val, fwd_m_i, wb_i);
    assign op_b = fwd_val(dx_q.rt, dx_q.rt_val, fwd_m_i, wb_i);

    // Address offsets are signed, logic immediates are not
    assign imm_ext = (dx_q.mem_read || dx_q.mem_write) ? {{16{dx_q.imm[15]}}, dx_q.imm}
                                                       : {16'h0000, dx_q.imm};
    assign src_b   = dx_q.imm_sel ? imm_ext : op_b;

    always_comb begin
        case (dx_q.alu_op)
            ALU_ADD: alu_res = op_a + src_b;
            ALU_SUB: alu_res = op_a - src_b;
            ALU_OR:  alu_res = op_a | src_b;
            default: alu_res = {src_b[15:0], 16'h0000};
        endcase
    end

    always_comb begin
        xm_o            = '0;
        xm_o.pc         = dx_q.pc;
        xm_o.alu_res    = alu_res;
        xm_o.store_data = op_b;
        xm_o.rt         = dx_q.rt;
        xm_o.dst        = dx_q.dst;
        xm_o.mem_read   = dx_q.mem_read;
        xm_o.mem_write  = dx_q.mem_write;
        xm_o.tnew       = (dx_q.tnew == '0) ? '0 : tnew_t'(dx_q.tnew - 2'd1);
    end

endmodule

/* rtl/memory_stage.sv */
module memory_stage (
    input  logic            clk_i,
    input  logic            rst_n_i,
    input  mips_pkg::xm_t   xm_i,
    output mips_pkg::word_t m_data_addr_o,
    output mips_pkg::word_t m_data_wdata_o,
    output mips_pkg::word_t m_inst_addr_o,
    output logic [3:0]      m_data_byteen_o,
    input  mips_pkg::word_t m_data_rdata_i,
    output mips_pkg::xm_t   fwd_m_o,
    output mips_pkg::wb_t   wb_o
);
    import mips_pkg::*;

    xm_t xm_q;
    mw_t mw_d;
    mw_t mw_q;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            xm_q <= '0;
            mw_q <= '0;
        end else begin
            xm_q <= xm_i;
            mw_q <= mw_d;
        end
    end

    assign fwd_m_o = xm_q;

    ////////////////////////////////////////
    // Data port, word accesses only

    assign m_data_addr_o   = xm_q.alu_res;
    assign m_inst_addr_o   = xm_q.pc;
    assign m_data_byteen_o = {4{xm_q.mem_write}};
    assign m_data_wdata_o  = (wb_o.we && wb_o.dst == xm_q.rt) ? wb_o.data : xm_q.store_data;

    always_comb begin
        mw_d.pc    = xm_q.pc;
        mw_d.value = xm_q.mem_read ? m_data_rdata_i : xm_q.alu_res;
        mw_d.dst   = xm_q.dst;
        // $zero never shows up on the trace
        mw_d.we    = xm_q.dst != '0;
    end

    always_comb begin
        wb_o.we   = mw_q.we;
        wb_o.dst  = mw_q.dst;
        wb_o.data = mw_q.value;
        wb_o.pc   = mw_q.pc;
    end

    // Whole words only reach the data port on an aligned address
    word_aligned_access_a: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        (xm_q.mem_read || xm_q.mem_write) |-> m_data_addr_o[1:0] == 2'b00
    );

endmodule

/* rtl/mips_core.sv */
module mips_core #(
    parameter mips_pkg::word_t RESET_PC = mips_pkg::RESET_PC
) (
    input  logic                clk_i,
    input  logic                rst_n_i,
    output mips_pkg::word_t     i_inst_addr_o,
    input  mips_pkg::word_t     i_inst_rdata_i,
    output mips_pkg::word_t     m_data_addr_o,
    output mips_pkg::word_t     m_data_wdata_o,
    output mips_pkg::word_t     m_inst_addr_o,
    output logic [3:0]          m_data_byteen_o,
    input  mips_pkg::word_t     m_data_rdata_i,
    output logic                w_grf_we_o,
    output mips_pkg::reg_addr_t w_grf_addr_o,
    output mips_pkg::word_t     w_grf_wdata_o,
    output mips_pkg::word_t     w_inst_addr_o
);
    import mips_pkg::*;

    fd_t   fd;
    dx_t   dx;
    dx_t   dx_q;
    xm_t   xm;
    xm_t   fwd_m;
    wb_t   wb;
    logic  stall;
    logic  redirect;
    word_t redirect_pc;

    fetch_stage #(
        .RESET_PC(RESET_PC)
    ) u_fetch (
        .clk_i          (clk_i),
        .rst_n_i        (rst_n_i),
        .stall_i        (stall),
        .redirect_i     (redirect),
        .redirect_pc_i  (redirect_pc),
        .i_inst_addr_o  (i_inst_addr_o),
        .i_inst_rdata_i (i_inst_rdata_i),
        .fd_o           (fd)
    );

    decode_stage u_decode (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .fd_i          (fd),
        .dx_q_i        (dx_q),
        .fwd_m_i       (fwd_m),
        .wb_i          (wb),
        .stall_o       (stall),
        .redirect_o    (redirect),
        .redirect_pc_o (redirect_pc),
        .dx_o          (dx)
    );

    execute_stage u_execute (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .dx_i    (dx),
        .fwd_m_i (fwd_m),
        .wb_i    (wb),
        .dx_q_o  (dx_q),
        .xm_o    (xm)
    );

    memory_stage u_memory (
        .clk_i           (clk_i),
        .rst_n_i         (rst_n_i),
        .xm_i            (xm),
        .m_data_addr_o   (m_data_addr_o),
        .m_data_wdata_o  (m_data_wdata_o),
        .m_inst_addr_o   (m_inst_addr_o),
        .m_data_byteen_o (m_data_byteen_o),
        .m_data_rdata_i  (m_data_rdata_i),
        .fwd_m_o         (fwd_m),
        .wb_o            (wb)
    );

    // Writeback trace
    assign w_grf_we_o    = wb.we;
    assign w_grf_addr_o  = wb.dst;
    assign w_grf_wdata_o = wb.data;
    assign w_inst_addr_o = wb.pc;

endmodule

/* tests/tb_mips_core.sv */
module tb_mips_core;
    timeunit 1ns;
    timeprecision 1ps;

    localparam logic [5:0] OPC_SPECIAL = 6'h00;
    localparam logic [5:0] OPC_J       = 6'h02;
    localparam logic [5:0] OPC_BEQ     = 6'h04;
    localparam logic [5:0] OPC_ORI     = 6'h0d;
    localparam logic [5:0] OPC_LUI     = 6'h0f;
    localparam logic [5:0] OPC_LW      = 6'h23;
    localparam logic [5:0] OPC_SW      = 6'h2b;
    localparam logic [5:0] FN_ADDU     = 6'h21;
    localparam logic [5:0] FN_SUBU     = 6'h23;

    typedef struct packed {
        logic [31:0] pc;
        logic [4:0]  rd;
        logic [31:0] val;
    } wr_rec_t;

    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] addr;
        logic [31:0] data;
    } st_rec_t;

    logic        clk_i;
    logic        rst_n_i;
    logic [31:0] i_inst_addr_o;
    logic [31:0] i_inst_rdata_i;
    logic [31:0] m_data_addr_o;
    logic [31:0] m_data_wdata_o;
    logic [31:0] m_inst_addr_o;
    logic [3:0]  m_data_byteen_o;
    logic [31:0] m_data_rdata_i;
    logic        w_grf_we_o;
    logic [4:0]  w_grf_addr_o;
    logic [31:0] w_grf_wdata_o;
    logic [31:0] w_inst_addr_o;

    logic [31:0] imem [256];
    logic [31:0] dmem [256];
    wr_rec_t     exp_wr [$];
    st_rec_t     exp_st [$];
    wr_rec_t     wr_got;
    st_rec_t     st_got;
    integer      seed;
    int          n_instr;
    logic [31:0] end_pc;
    logic        prog_ready;

    mips_core #(
        .RESET_PC(32'h0000_3000)
    ) dut0 (
        .clk_i           (clk_i),
        .rst_n_i         (rst_n_i),
        .i_inst_addr_o   (i_inst_addr_o),
        .i_inst_rdata_i  (i_inst_rdata_i),
        .m_data_addr_o   (m_data_addr_o),
        .m_data_wdata_o  (m_data_wdata_o),
        .m_inst_addr_o   (m_inst_addr_o),
        .m_data_byteen_o (m_data_byteen_o),
        .m_data_rdata_i  (m_data_rdata_i),
        .w_grf_we_o      (w_grf_we_o),
        .w_grf_addr_o    (w_grf_addr_o),
        .w_grf_wdata_o   (w_grf_wdata_o),
        .w_inst_addr_o   (w_inst_addr_o)
    );

    // Both memories answer within the cycle, 1 KB windows
    assign i_inst_rdata_i = imem[i_inst_addr_o[9:2]];
    assign m_data_rdata_i = dmem[m_data_addr_o[9:2]];

    initial begin
        clk_i = 1'b0;
        forever #4 clk_i = ~clk_i;
    end

    ////////////////////////////////////////
    // Reporting

    task automatic stop_with_failure(input string why);
        $display("%s", why);
        $display("Simulation failed");
        $fatal(1);
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] exp_v,
                                   input logic [31:0] act_v);
        stop_with_failure($sformatf("CHECK FAILED %s expected 0x%08h actual 0x%08h",
                                    name, exp_v, act_v));
    endtask

    ////////////////////////////////////////
    // Program builder

    function automatic logic [31:0] mem_fill(input logic [31:0] addr);
        return {addr[15:0], addr[31:16]} ^ 32'hc3a5_0f96;
    endfunction

    function automatic logic [31:0] r_type(input logic [5:0] fn, input logic [4:0] rs,
                                           input logic [4:0] rt, input logic [4:0] rd);
        return {OPC_SPECIAL, rs, rt, rd, 5'd0, fn};
    endfunction

    function automatic logic [31:0] i_type(input logic [5:0] op, input logic [4:0] rs,
                                           input logic [4:0] rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic logic [31:0] here();
        return 32'h0000_3000 + 32'(n_instr * 4);
    endfunction

    // Random mix stays in $1..$15, $20..$29 are fixed roles
    function automatic logic [4:0] pick_reg();
        return 5'd1 + 5'($unsigned($random(seed)) % 15);
    endfunction

    task automatic emit(input logic [31:0] word);
        imem[n_instr] = word;
        n_instr++;
    endtask

    task automatic build_program();
        logic [4:0]  d;
        logic [4:0]  prev;
        logic [4:0]  prev2;
        logic [15:0] imm;
        logic [15:0] off;
        logic [31:0] tgt;
        int          sel;
        for (int r = 1; r < 16; r++) begin
            emit(i_type(OPC_LUI, 5'd0, 5'(r), 16'($random(seed))));
            emit(i_type(OPC_ORI, 5'(r), 5'(r), 16'($random(seed))));
        end
        // $0 stays zero and never shows up on the trace
        emit(i_type(OPC_ORI, 5'd1, 5'd0, 16'h0055));
        emit(r_type(FN_ADDU, 5'd0, 5'd3, 5'd2));
        // Random ALU mix
        for (int k = 0; k < 24; k++) begin
            d   = pick_reg();
            imm = 16'($random(seed));
            sel = $unsigned($random(seed)) % 4;
            case (sel)
                0: emit(i_type(OPC_LUI, 5'd0, d, imm));
                1: emit(i_type(OPC_ORI, pick_reg(), d, imm));
                2: emit(r_type(FN_ADDU, pick_reg(), pick_reg(), d));
                default: emit(r_type(FN_SUBU, pick_reg(), pick_reg(), d));
            endcase
        end
        // Dependence chain, distance one and two
        prev2 = 5'd1;
        prev  = 5'd2;
        for (int k = 0; k < 12; k++) begin
            d = pick_reg();
            case (k % 3)
                0: emit(r_type(FN_ADDU, prev, prev2, d));
                1: emit(r_type(FN_SUBU, prev2, prev, d));
                default: emit(i_type(OPC_ORI, prev, d, 16'($random(seed))));
            endcase
            prev2 = prev;
            prev  = d;
        end
        // Loads and stores around base 0x100 in $20
        emit(i_type(OPC_LUI, 5'd0, 5'd20, 16'h0000));
        emit(i_type(OPC_ORI, 5'd20, 5'd20, 16'h0100));
        for (int k = 0; k < 4; k++) begin
            off = {8'h00, 6'($random(seed)), 2'b00};
            emit(r_type(FN_ADDU, pick_reg(), pick_reg(), 5'd21));
            emit(i_type(OPC_SW, 5'd20, 5'd21, off));
            emit(i_type(OPC_LW, 5'd20, 5'd22, off));
            emit(r_type(FN_SUBU, 5'd22, pick_reg(), 5'd23));
            emit(i_type(OPC_LW, 5'd20, 5'd24, off ^ 16'h0040));
            emit(i_type(OPC_SW, 5'd20, 5'd24, off ^ 16'h0080));
        end
        // beq taken, compare operand from the instruction before
        emit(r_type(FN_ADDU, 5'd1, 5'd0, 5'd26));
        emit(i_type(OPC_BEQ, 5'd26, 5'd1, 16'd2));
        emit(i_type(OPC_ORI, 5'd0, 5'd27, 16'h0011));
        emit(i_type(OPC_ORI, 5'd0, 5'd27, 16'h0022));
        emit(i_type(OPC_ORI, 5'd27, 5'd28, 16'h0033));
        // beq not taken, $1 - 0x100 never equals $1
        emit(r_type(FN_SUBU, 5'd1, 5'd20, 5'd26));
        emit(i_type(OPC_BEQ, 5'd26, 5'd1, 16'd2));
        emit(i_type(OPC_ORI, 5'd26, 5'd27, 16'h0044));
        emit(i_type(OPC_ORI, 5'd0, 5'd28, 16'h0055));
        emit(r_type(FN_ADDU, 5'd27, 5'd28, 5'd29));
        // Compare fed straight from a load
        emit(i_type(OPC_SW, 5'd20, 5'd1, 16'h0020));
        emit(i_type(OPC_LW, 5'd20, 5'd29, 16'h0020));
        emit(i_type(OPC_BEQ, 5'd29, 5'd1, 16'd2));
        emit(r_type(FN_ADDU, 5'd29, 5'd2, 5'd27));
        emit(i_type(OPC_ORI, 5'd0, 5'd27, 16'h0077));
        emit(r_type(FN_SUBU, 5'd27, 5'd29, 5'd28));
        // j over one instruction
        tgt = here() + 32'd12;
        emit({OPC_J, tgt[27:2]});
        emit(i_type(OPC_ORI, 5'd0, 5'd27, 16'h0066));
        emit(i_type(OPC_ORI, 5'd0, 5'd27, 16'h0099));
        emit(r_type(FN_ADDU, 5'd27, 5'd1, 5'd28));
        end_pc = here();
    endtask

    ////////////////////////////////////////
    // Reference ISA model with one delay slot

    function automatic void run_reference();
        logic [31:0] rf [32];
        logic [31:0] mem [256];
        logic [31:0] pc;
        logic [31:0] npc;
        logic [31:0] target;
        logic [31:0] ins;
        logic [31:0] addr;
        logic [31:0] res;
        logic [31:0] sext;
        logic [4:0]  wdst;
        int          steps;
        for (int i = 0; i < 256; i++) begin
            mem[i] = mem_fill(32'(i * 4));
        end
        rf[0] = '0;
        pc    = 32'h0000_3000;
        npc   = 32'h0000_3004;
        steps = 0;
        while (pc != end_pc && steps < 4096) begin
            ins    = imem[pc[9:2]];
            sext   = {{16{ins[15]}}, ins[15:0]};
            addr   = rf[ins[25:21]] + sext;
            target = npc + 32'd4;
            wdst   = 5'd0;
            res    = '0;
            case (ins[31:26])
                OPC_SPECIAL: begin
                    if (ins[5:0] == FN_ADDU) begin
                        wdst = ins[15:11];
                        res  = rf[ins[25:21]] + rf[ins[20:16]];
                    end else if (ins[5:0] == FN_SUBU) begin
                        wdst = ins[15:11];
                        res  = rf[ins[25:21]] - rf[ins[20:16]];
                    end
                end
                OPC_ORI: begin
                    wdst = ins[20:16];
                    res  = rf[ins[25:21]] | {16'h0000, ins[15:0]};
                end
                OPC_LUI: begin
                    wdst = ins[20:16];
                    res  = {ins[15:0], 16'h0000};
                end
                OPC_LW: begin
                    wdst = ins[20:16];
                    res  = mem[addr[9:2]];
                end
                OPC_SW: begin
                    mem[addr[9:2]] = rf[ins[20:16]];
                    exp_st.push_back('{pc, addr, rf[ins[20:16]]});
                end
                OPC_BEQ: begin
                    if (rf[ins[25:21]] == rf[ins[20:16]]) target = npc + (sext << 2);
                end
                OPC_J: target = {npc[31:28], ins[25:0], 2'b00};
                default: ;
            endcase
            if (wdst != 5'd0) begin
                rf[wdst] = res;
                exp_wr.push_back('{pc, wdst, res});
            end
            pc  = npc;
            npc = target;
            steps++;
        end
    endfunction

    ////////////////////////////////////////
    // Trace and store compare, data memory write

    always @(negedge clk_i) begin
        if (rst_n_i && w_grf_we_o) begin
            assert (exp_wr.size() != 0)
                else stop_with_failure("A register write appeared after the last expected one");
            wr_got = exp_wr.pop_front();
            assert (w_inst_addr_o == wr_got.pc)
                else report_mismatch("w_inst_addr_o", wr_got.pc, w_inst_addr_o);
            assert (w_grf_addr_o == wr_got.rd)
                else report_mismatch("w_grf_addr_o", 32'(wr_got.rd), 32'(w_grf_addr_o));
            assert (w_grf_wdata_o == wr_got.val)
                else report_mismatch("w_grf_wdata_o", wr_got.val, w_grf_wdata_o);
        end
        if (rst_n_i && m_data_byteen_o != 4'h0) begin
            assert (exp_st.size() != 0)
                else stop_with_failure("A data store appeared after the last expected one");
            st_got = exp_st.pop_front();
            assert (m_data_byteen_o == 4'hf)
                else report_mismatch("m_data_byteen_o", 32'hf, 32'(m_data_byteen_o));
            assert (m_inst_addr_o == st_got.pc)
                else report_mismatch("m_inst_addr_o", st_got.pc, m_inst_addr_o);
            assert (m_data_addr_o == st_got.addr)
                else report_mismatch("m_data_addr_o", st_got.addr, m_data_addr_o);
            assert (m_data_wdata_o == st_got.data)
                else report_mismatch("m_data_wdata_o", st_got.data, m_data_wdata_o);
            dmem[m_data_addr_o[9:2]] = m_data_wdata_o;
        end
    end

    initial begin : watchdog
        wait (prog_ready);
        repeat (n_instr * 4 + 50) @(posedge clk_i);
        stop_with_failure("Timeout, the pipeline did not finish the program in time");
    end

    initial begin
        rst_n_i    = 1'b0;
        prog_ready = 1'b0;
        seed       = 32'hf0e5_74f8;
        n_instr    = 0;
        for (int i = 0; i < 256; i++) begin
            imem[i] = '0;
            dmem[i] = mem_fill(32'(i * 4));
        end
        build_program();
        run_reference();
        prog_ready = 1'b1;

        repeat (5) @(posedge clk_i);
        @(negedge clk_i);
        rst_n_i = 1'b1;
        #1;
        assert (i_inst_addr_o == 32'h0000_3000)
            else report_mismatch("i_inst_addr_o", 32'h0000_3000, i_inst_addr_o);
        assert (w_grf_we_o == 1'b0)
            else report_mismatch("w_grf_we_o", 32'h0, 32'(w_grf_we_o));
        assert (m_data_byteen_o == 4'h0)
            else report_mismatch("m_data_byteen_o", 32'h0, 32'(m_data_byteen_o));

        while (exp_wr.size() != 0 || exp_st.size() != 0) @(negedge clk_i);
        // Extra cycles so a stray write would still be caught
        repeat (8) @(negedge clk_i);
        if (exp_wr.size() == 0 && exp_st.size() == 0) begin
            $display("Simulation completed successfully");
            $finish;
        end else begin
            stop_with_failure("Expected writes were left over at the end of the run");
        end
    end

endmodule

/* mips_core.f */
rtl/mips_pkg.sv
rtl/fetch_stage.sv
rtl/decode_stage.sv
rtl/execute_stage.sv
rtl/memory_stage.sv
rtl/mips_core.sv
tests/tb_mips_core.sv

/* Bender.yml */
package:
  name: mips_core

sources:
  - rtl/mips_pkg.sv
  - rtl/fetch_stage.sv
  - rtl/decode_stage.sv
  - rtl/execute_stage.sv
  - rtl/memory_stage.sv
  - rtl/mips_core.sv
  - target: test
    files:
      - tests/tb_mips_core.sv
